/* mcl_consts.svh */
// transmit fifo subsystem constants
`ifndef MCL_CONSTS_SVH
`define MCL_CONSTS_SVH

// --------------------
// sizing
// --------------------
`define MCL_NUM_CHANNELS 4   // transmit channels
`define MCL_FIFO_DEPTH   4   // entries per channel, power of two, at least 2

// --------------------
// bus widths
// --------------------
`define MCL_ADDR_W 32
`define MCL_DATA_W 32
`define MCL_STRB_W 4

// --------------------
// register map
// --------------------
`define MCL_BASE_ADDR   32'h0000_1000   // start of channel 0 window
`define MCL_CHAN_SPAN_W 4               // 16 byte window per channel
`define MCL_OFS_TDR     4'h0            // transmit data register
`define MCL_OFS_ISR     4'h4            // interrupt status register

// isr fields
`define MCL_ISR_TC_BIT 0   // transmit complete, write one to clear

`endif

/* axil_pkg.sv */
// axi-lite write side types
`include "mcl_consts.svh"

package axil_pkg;

  // write response code, only the two this block ever returns
  typedef enum logic [1:0] {
    AXIL_OKAY   = 2'b00,
    AXIL_DECERR = 2'b11
  } axil_resp_e;

  // --------------------
  // address decode fields
  // --------------------

  // byte offset from the start of the register block
  function automatic logic [`MCL_ADDR_W-1:0] rel_addr(input logic [`MCL_ADDR_W-1:0] addr);
    return addr - `MCL_BASE_ADDR;
  endfunction

  // below base wraps to a large value, so one compare covers both ends
  function automatic logic addr_in_block(input logic [`MCL_ADDR_W-1:0] addr);
    return rel_addr(addr) < `MCL_ADDR_W'(`MCL_NUM_CHANNELS << `MCL_CHAN_SPAN_W);
  endfunction

  function automatic logic [`MCL_ADDR_W-1:0] addr_window(input logic [`MCL_ADDR_W-1:0] addr);
    return rel_addr(addr) >> `MCL_CHAN_SPAN_W;   // channel number
  endfunction

  function automatic logic [`MCL_CHAN_SPAN_W-1:0] addr_offset(input logic [`MCL_ADDR_W-1:0] addr);
    return addr[`MCL_CHAN_SPAN_W-1:0];   // base is window aligned
  endfunction

endpackage

/* fifo_regs_pkg.sv */
// channel side register types
`include "mcl_consts.svh"

package fifo_regs_pkg;

  // at least one bit, even for a single channel build
  localparam int chan_idx_w_lp = (`MCL_NUM_CHANNELS > 1) ? $clog2(`MCL_NUM_CHANNELS) : 1;

  typedef logic [chan_idx_w_lp-1:0] chan_idx_t;

  // --------------------
  // register word views
  // --------------------

  // isr layout, tc flag is the lowest bit
  typedef struct packed {
    logic [`MCL_DATA_W-1:`MCL_ISR_TC_BIT+1] rsvd;   // reserved, ignored on write
    logic                                  tc;     // write one to clear
  } isr_word_t;

  // one wdata beat, viewed as payload for tdr hits
  // and as status fields for isr hits
  typedef union packed {
    logic [`MCL_DATA_W-1:0] tdr_data;
    isr_word_t              isr;
  } reg_word_u;

endpackage

/* axil_write_decoder.sv */
// axi-lite write decoder
`include "mcl_consts.svh"

module axil_write_decoder (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // write address channel
  input  logic [`MCL_ADDR_W-1:0]       awaddr_i,
  input  logic                         awvalid_i,
  output logic                         awready_o,
  // write data channel
  input  logic [`MCL_DATA_W-1:0]       wdata_i,
  input  logic [`MCL_STRB_W-1:0]       wstrb_i,
  input  logic                         wvalid_i,
  output logic                         wready_o,
  // write response channel
  output axil_pkg::axil_resp_e         bresp_o,
  output logic                         bvalid_o,
  input  logic                         bready_i,
  // channel strobes
  output logic [`MCL_NUM_CHANNELS-1:0] push_v_o,
  output logic [`MCL_DATA_W-1:0]       push_data_o,
  input  logic [`MCL_NUM_CHANNELS-1:0] push_ready_i,
  output logic [`MCL_NUM_CHANNELS-1:0] clear_tc_o
);

  import axil_pkg::*;
  import fifo_regs_pkg::*;

  localparam int num_chan_lp = `MCL_NUM_CHANNELS;

  localparam logic [1:0] st_idle_lp = 2'd0;
  localparam logic [1:0] st_addr_lp = 2'd1;
  localparam logic [1:0] st_data_lp = 2'd2;
  localparam logic [1:0] st_resp_lp = 2'd3;

  logic [1:0] state_r, state_n;

  chan_idx_t  chan_r;      // addressed channel
  logic       tdr_hit_r;
  logic       isr_hit_r;
  axil_resp_e bresp_r;

  logic                        aw_hs, w_hs;
  logic                        in_block;
  logic [`MCL_CHAN_SPAN_W-1:0] ofs;
  logic [num_chan_lp-1:0]      chan_sel;
  reg_word_u                   wdata_u;

  assign aw_hs = awvalid_i & awready_o;
  assign w_hs  = wvalid_i & wready_o;

  // --------------------
  // write fsm
  // --------------------
  always_comb begin
    state_n = state_r;
    case (state_r)
      st_idle_lp: if (awvalid_i) state_n = st_addr_lp;
      st_addr_lp: state_n = st_data_lp;   // address taken here
      st_data_lp: if (w_hs) state_n = st_resp_lp;
      st_resp_lp: if (bready_i) state_n = st_idle_lp;
      default:    state_n = st_idle_lp;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle_lp;
    end else begin
      state_r <= state_n;
    end
  end

  // --------------------
  // address decode
  // --------------------
  assign in_block = addr_in_block(awaddr_i);
  assign ofs      = addr_offset(awaddr_i);

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      chan_r    <= chan_idx_t'(addr_window(awaddr_i));
      tdr_hit_r <= in_block && (ofs == `MCL_OFS_TDR);
      isr_hit_r <= in_block && (ofs == `MCL_OFS_ISR);
    end
  end

  assign chan_sel = num_chan_lp'(1) << chan_r;

  // tdr writes wait on the target fifo, anything else goes straight through
  assign awready_o = (state_r == st_addr_lp);
  assign wready_o  = (state_r == st_data_lp) && (tdr_hit_r ? push_ready_i[chan_r] : 1'b1);

  // --------------------
  // channel strobes
  // --------------------
  assign wdata_u     = wdata_i;
  assign push_data_o = wdata_u.tdr_data;   // shared by every channel
  assign push_v_o    = {num_chan_lp{w_hs & tdr_hit_r}} & chan_sel;
  assign clear_tc_o  = {num_chan_lp{w_hs & isr_hit_r & wdata_u.isr.tc}} & chan_sel;

  // response code captured with the data beat
  always_ff @(posedge clk_i) begin
    if (w_hs) begin
      bresp_r <= (tdr_hit_r | isr_hit_r) ? AXIL_OKAY : AXIL_DECERR;
    end
  end

  assign bvalid_o = (state_r == st_resp_lp);
  assign bresp_o  = bresp_r;

  // --------------------
  // checks
  // --------------------
  a_push_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(push_v_o))
    else $error("more than one channel pushed at once");

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_o && !bready_i |=> bvalid_o)
    else $error("bvalid dropped before bready");

  // strobes are not honoured, partial writes land as full words
  a_full_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    w_hs |-> (wstrb_i == '1))
    else $warning("partial write strobe treated as full word");

endmodule

/* tx_fifo_channel.sv */
// transmit fifo channel
`include "mcl_consts.svh"

module tx_fifo_channel #(
  parameter int depth_p = `MCL_FIFO_DEPTH   // power of two, at least 2
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // push side, from the decoder
  input  logic                   push_v_i,
  input  logic [`MCL_DATA_W-1:0] push_data_i,
  output logic                   push_ready_o,
  // pop side, to the arbiter
  output logic                   fifo_v_o,
  output logic [`MCL_DATA_W-1:0] fifo_data_o,
  input  logic                   pop_i,
  // transmit complete status
  input  logic                   clear_tc_i,
  output logic                   isr_tc_o
);

  localparam int ptr_w_lp = $clog2(depth_p);
  localparam int cnt_w_lp = $clog2(depth_p + 1);

  logic [`MCL_DATA_W-1:0] mem_r [depth_p];
  logic [ptr_w_lp-1:0]    rd_ptr_r, wr_ptr_r;   // wrap on their own
  logic [cnt_w_lp-1:0]    count_r;

  logic do_push, do_pop;
  logic set_tc;
  logic tc_r;

  // --------------------
  // buffer
  // --------------------
  assign push_ready_o = (count_r != cnt_w_lp'(depth_p));
  assign fifo_v_o     = (count_r != '0);
  assign fifo_data_o  = mem_r[rd_ptr_r];   // head word

  assign do_push = push_v_i & push_ready_o;
  assign do_pop  = pop_i & fifo_v_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_r[wr_ptr_r] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (do_push) wr_ptr_r <= wr_ptr_r + 1'b1;
      if (do_pop)  rd_ptr_r <= rd_ptr_r + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;   // idle or push and pop together
      endcase
    end
  end

  // --------------------
  // transmit complete flag
  // --------------------

  // last word leaves and nothing refills it this cycle
  assign set_tc = do_pop & ~do_push & (count_r == cnt_w_lp'(1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tc_r <= 1'b0;
    end else if (set_tc) begin
      tc_r <= 1'b1;   // set beats a clear in the same cycle
    end else if (clear_tc_i) begin
      tc_r <= 1'b0;
    end
  end

  assign isr_tc_o = tc_r;

  // --------------------
  // checks
  // --------------------
  a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push_v_i |-> push_ready_o)
    else $error("push into a full fifo");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> fifo_v_o)
    else $error("pop from an empty fifo");

endmodule

/* tx_drain_arbiter.sv */
// round-robin drain arbiter
`include "mcl_consts.svh"

module tx_drain_arbiter (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  // fifo heads
  input  logic [`MCL_NUM_CHANNELS-1:0]                  fifo_v_i,
  input  logic [`MCL_NUM_CHANNELS-1:0][`MCL_DATA_W-1:0] fifo_data_i,
  output logic [`MCL_NUM_CHANNELS-1:0]                  pop_o,
  // shared output stream
  output logic [`MCL_DATA_W-1:0]                        stream_data_o,
  output fifo_regs_pkg::chan_idx_t                      stream_chan_o,
  output logic                                          stream_v_o,
  input  logic                                          stream_ready_i
);

  import fifo_regs_pkg::*;

  localparam int num_chan_lp = `MCL_NUM_CHANNELS;

  chan_idx_t last_r;        // last channel served
  logic      hold_v_r;      // an offer is stalled
  chan_idx_t hold_chan_r;   // channel of the stalled offer

  chan_idx_t search_chan;
  chan_idx_t sel_chan;
  logic      found;
  logic      xfer;

  // --------------------
  // round-robin search
  // --------------------
  always_comb begin
    found       = 1'b0;
    search_chan = last_r;
    for (int off = 1; off <= num_chan_lp; off++) begin
      chan_idx_t cand;
      cand = chan_idx_t'((int'(last_r) + off) % num_chan_lp);
      if (!found && fifo_v_i[cand]) begin
        found       = 1'b1;
        search_chan = cand;
      end
    end
  end

  // a stalled offer keeps its channel even if an earlier one fills up
  assign sel_chan = hold_v_r ? hold_chan_r : search_chan;

  assign stream_v_o    = |fifo_v_i;
  assign stream_chan_o = sel_chan;
  assign stream_data_o = fifo_data_i[sel_chan];

  assign xfer  = stream_v_o & stream_ready_i;
  assign pop_o = xfer ? (num_chan_lp'(1) << sel_chan) : '0;

  // --------------------
  // pointer and hold state
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_r   <= chan_idx_t'(num_chan_lp - 1);   // channel 0 first
      hold_v_r <= 1'b0;
    end else if (xfer) begin
      last_r   <= sel_chan;
      hold_v_r <= 1'b0;
    end else if (stream_v_o) begin
      hold_v_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stream_v_o && !stream_ready_i) begin
      hold_chan_r <= sel_chan;
    end
  end

  // --------------------
  // checks
  // --------------------
  a_pop_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(pop_o))
    else $error("more than one fifo popped");

  a_offer_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    stream_v_o && !stream_ready_i |=>
      stream_v_o && $stable(stream_chan_o) && $stable(stream_data_o))
    else $error("stream offer changed under back-pressure");

endmodule

/* axil_tx_fifos.sv */
// axi-lite transmit fifo subsystem
`include "mcl_consts.svh"

module axil_tx_fifos (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // axi-lite write channels
  input  logic [`MCL_ADDR_W-1:0]       awaddr_i,
  input  logic                         awvalid_i,
  output logic                         awready_o,
  input  logic [`MCL_DATA_W-1:0]       wdata_i,
  input  logic [`MCL_STRB_W-1:0]       wstrb_i,
  input  logic                         wvalid_i,
  output logic                         wready_o,
  output axil_pkg::axil_resp_e         bresp_o,
  output logic                         bvalid_o,
  input  logic                         bready_i,
  // output stream
  output logic [`MCL_DATA_W-1:0]       stream_data_o,
  output fifo_regs_pkg::chan_idx_t     stream_chan_o,
  output logic                         stream_v_o,
  input  logic                         stream_ready_i,
  // interrupts
  output logic [`MCL_NUM_CHANNELS-1:0] isr_tc_o
);

  logic [`MCL_NUM_CHANNELS-1:0]                  push_v, push_ready, clear_tc;
  logic [`MCL_DATA_W-1:0]                        push_data;
  logic [`MCL_NUM_CHANNELS-1:0]                  fifo_v, pop;
  logic [`MCL_NUM_CHANNELS-1:0][`MCL_DATA_W-1:0] fifo_data;

  axil_write_decoder u_decoder (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .awaddr_i     (awaddr_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .bresp_o      (bresp_o),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .push_v_o     (push_v),
    .push_data_o  (push_data),
    .push_ready_i (push_ready),
    .clear_tc_o   (clear_tc)
  );

  // one fifo and tc flag per channel
  for (genvar i = 0; i < `MCL_NUM_CHANNELS; i++) begin : g_chan
    tx_fifo_channel #(
      .depth_p (`MCL_FIFO_DEPTH)
    ) u_chan (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .push_v_i     (push_v[i]),
      .push_data_i  (push_data),
      .push_ready_o (push_ready[i]),
      .fifo_v_o     (fifo_v[i]),
      .fifo_data_o  (fifo_data[i]),
      .pop_i        (pop[i]),
      .clear_tc_i   (clear_tc[i]),
      .isr_tc_o     (isr_tc_o[i])
    );
  end

  tx_drain_arbiter u_arbiter (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fifo_v_i       (fifo_v),
    .fifo_data_i    (fifo_data),
    .pop_o          (pop),
    .stream_data_o  (stream_data_o),
    .stream_chan_o  (stream_chan_o),
    .stream_v_o     (stream_v_o),
    .stream_ready_i (stream_ready_i)
  );

endmodule

/* tb_axil_tx_fifos.sv */
// axi-lite transmit fifo testbench
`include "mcl_consts.svh"

module tb_axil_tx_fifos;
  timeunit 1ns;
  timeprecision 100ps;

  import axil_pkg::*;
  import fifo_regs_pkg::*;

  localparam int nch_lp     = `MCL_NUM_CHANNELS;
  localparam int write_c_lp = 10;                                   // cycles per write with margin
  localparam int writes_lp  = 6 * nch_lp + `MCL_FIFO_DEPTH + 4;      // writes over all tests
  localparam int limit_lp   = 2 * (writes_lp * write_c_lp + 120);    // plus drains and holds

  logic        clk_i, reset_i;
  logic [31:0] awaddr_i, wdata_i, stream_data_o;
  logic [3:0]  wstrb_i;
  logic        awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
  axil_resp_e  bresp_o;
  chan_idx_t   stream_chan_o;
  logic        stream_v_o, stream_ready_i;
  logic [nch_lp-1:0] isr_tc_o;

  // scoreboard with one ring per channel
  logic [31:0]       exp_mem [nch_lp][64];
  logic [5:0]        exp_wr [nch_lp], exp_rd [nch_lp], exp_count [nch_lp];
  logic [nch_lp-1:0] exp_tc, set_ev, clr_ev;
  chan_idx_t         tgt_chan, last_served, rr_chan;
  logic              tgt_tdr, tgt_isr, rr_on, rr_armed;
  axil_resp_e        exp_resp;
  logic              xfer, push_hs, isr_hs;
  logic [31:0]       exp_head;
  logic [31:0]       lcg_state = 32'd24;
  int                errors, tests_run, tests_failed, err_mark, cycles;

  axil_tx_fifos DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] chan_addr(input int c, input logic [`MCL_CHAN_SPAN_W-1:0] ofs);
    return `MCL_BASE_ADDR + (c << `MCL_CHAN_SPAN_W) + ofs;
  endfunction

  // --------------------
  // reference model
  // --------------------
  assign xfer     = stream_v_o && stream_ready_i;
  assign push_hs  = wvalid_i && wready_o && tgt_tdr;
  assign isr_hs   = wvalid_i && wready_o && tgt_isr;
  assign exp_head = exp_mem[stream_chan_o][exp_rd[stream_chan_o]];

  always_comb begin
    int idx;
    rr_chan = last_served;
    for (int c = 0; c < nch_lp; c++) begin
      exp_count[c] = exp_wr[c] - exp_rd[c];
      set_ev[c] = xfer && stream_chan_o == chan_idx_t'(c) && exp_count[c] == 6'd1
                  && !(push_hs && tgt_chan == chan_idx_t'(c));   // refill keeps it busy
      clr_ev[c] = isr_hs && wdata_i[`MCL_ISR_TC_BIT] && tgt_chan == chan_idx_t'(c);
    end
    // walk down so the nearest loaded channel after the last one wins
    for (int k = nch_lp; k >= 1; k--) begin
      idx = (int'(last_served) + k) % nch_lp;
      if (exp_count[idx] != '0) rr_chan = chan_idx_t'(idx);
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int c = 0; c < nch_lp; c++) begin
        exp_wr[c] <= '0;
        exp_rd[c] <= '0;
      end
      exp_tc      <= '0;
      last_served <= '0;
      rr_armed    <= 1'b0;
    end else begin
      if (push_hs) begin
        exp_mem[tgt_chan][exp_wr[tgt_chan]] <= wdata_i;
        exp_wr[tgt_chan] <= exp_wr[tgt_chan] + 1'b1;
      end
      if (xfer) begin
        exp_rd[stream_chan_o] <= exp_rd[stream_chan_o] + 1'b1;
        last_served <= stream_chan_o;
      end
      exp_tc   <= set_ev | (exp_tc & ~clr_ev);   // set wins over clear
      rr_armed <= rr_on && (rr_armed || xfer);
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == limit_lp) begin
      $display("timeout: tests still running after %0d cycles", limit_lp);
      $display("tests failed");
      $finish;
    end
  end

  // --------------------
  // checks
  // --------------------
  a_stream_word: assert property (@(posedge clk_i) disable iff (reset_i)
    xfer |-> exp_count[stream_chan_o] != '0 && stream_data_o == exp_head)
    else begin
      errors++;
      $display("FAIL %0t: stream word %h on channel %0d not expected", $time,
               $sampled(stream_data_o), $sampled(stream_chan_o));
    end

  a_aw_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(awvalid_i) |=> awready_o ##1 !awready_o)
    else begin
      errors++;
      $display("FAIL %0t: awready not a single pulse one cycle after awvalid", $time);
    end

  a_bresp: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_o |-> bresp_o == exp_resp)
    else begin
      errors++;
      $display("FAIL %0t: bresp %0d, expected %0d", $time, $sampled(bresp_o), exp_resp);
    end

  a_full_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    wvalid_i && tgt_tdr && exp_count[tgt_chan] == `MCL_FIFO_DEPTH |-> !wready_o)
    else begin
      errors++;
      $display("FAIL %0t: wready high on full channel %0d", $time, tgt_chan);
    end

  a_round_robin: assert property (@(posedge clk_i) disable iff (reset_i)
    rr_armed && xfer |-> stream_chan_o == rr_chan)
    else begin
      errors++;
      $display("FAIL %0t: channel %0d served, expected %0d", $time,
               $sampled(stream_chan_o), $sampled(rr_chan));
    end

  a_offer_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    stream_v_o && !stream_ready_i |=>
      stream_v_o && $stable(stream_chan_o) && $stable(stream_data_o))
    else begin
      errors++;
      $display("FAIL %0t: stream offer changed while stalled", $time);
    end

  a_tc_flags: assert property (@(posedge clk_i) disable iff (reset_i)
    isr_tc_o == exp_tc)
    else begin
      errors++;
      $display("FAIL %0t: isr_tc %b, expected %b", $time, $sampled(isr_tc_o), exp_tc);
    end

  // --------------------
  // drivers
  // --------------------
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    logic      hit_tdr;
    logic      hit_isr;
    chan_idx_t hit_chan;
    hit_tdr  = 1'b0;
    hit_isr  = 1'b0;
    hit_chan = '0;
    // match against every register in the map
    for (int c = 0; c < nch_lp; c++) begin
      if (addr == chan_addr(c, `MCL_OFS_TDR)) begin
        hit_tdr  = 1'b1;
        hit_chan = chan_idx_t'(c);
      end
      if (addr == chan_addr(c, `MCL_OFS_ISR)) begin
        hit_isr  = 1'b1;
        hit_chan = chan_idx_t'(c);
      end
    end
    @(posedge clk_i);
    tgt_chan  <= hit_chan;
    tgt_tdr   <= hit_tdr;
    tgt_isr   <= hit_isr;
    exp_resp  <= (hit_tdr || hit_isr) ? AXIL_OKAY : AXIL_DECERR;
    awaddr_i  <= addr;
    awvalid_i <= 1'b1;
    do @(negedge clk_i); while (!awready_o);
    @(posedge clk_i);
    awvalid_i <= 1'b0;
    wdata_i   <= data;
    wvalid_i  <= 1'b1;
    do @(negedge clk_i); while (!wready_o);
    @(posedge clk_i);
    wvalid_i <= 1'b0;
    bready_i <= 1'b1;
    do @(negedge clk_i); while (!bvalid_o);
    @(posedge clk_i);
    bready_i <= 1'b0;
  endtask

  // ready low or random for n cycles, then released
  task automatic hold_stream(input int n, input bit random_ready);
    logic [31:0] r;
    repeat (n) begin
      r = next_rand();
      @(posedge clk_i);
      stream_ready_i <= random_ready ? r[17] : 1'b0;
    end
    @(posedge clk_i);
    stream_ready_i <= 1'b1;
  endtask

  task automatic wait_drained();
    do @(negedge clk_i); while (stream_v_o);
    repeat (2) @(posedge clk_i);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // --------------------
  // stimulus
  // --------------------
  initial begin
    reset_i        = 1'b1;
    awaddr_i       = '0;
    awvalid_i      = 1'b0;
    wdata_i        = '0;
    wstrb_i        = 4'hF;
    wvalid_i       = 1'b0;
    bready_i       = 1'b0;
    stream_ready_i = 1'b1;
    tgt_chan       = '0;
    tgt_tdr        = 1'b0;
    tgt_isr        = 1'b0;
    exp_resp       = AXIL_OKAY;
    rr_on          = 1'b0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    for (int c = 0; c < nch_lp; c++) begin
      repeat (2) write_reg(chan_addr(c, `MCL_OFS_TDR), next_rand());
    end
    wait_drained();
    finish_test("tdr writes to every channel");

    write_reg(chan_addr(nch_lp, `MCL_OFS_TDR), next_rand());   // just past the last window
    write_reg(`MCL_BASE_ADDR - 32'h10, next_rand());
    repeat (4) @(posedge clk_i);
    finish_test("out of range writes");

    @(posedge clk_i);
    stream_ready_i <= 1'b0;
    repeat (`MCL_FIFO_DEPTH) write_reg(chan_addr(nch_lp - 1, `MCL_OFS_TDR), next_rand());
    fork
      write_reg(chan_addr(nch_lp - 1, `MCL_OFS_TDR), next_rand());
      hold_stream(6, 1'b0);
    join
    wait_drained();
    finish_test("full fifo back-pressure");

    @(posedge clk_i);
    stream_ready_i <= 1'b0;
    rr_on          <= 1'b1;
    for (int c = 0; c < nch_lp; c++) begin
      repeat (2) write_reg(chan_addr(c, `MCL_OFS_TDR), next_rand());
    end
    hold_stream(30, 1'b1);
    wait_drained();
    rr_on <= 1'b0;
    finish_test("round-robin drain");

    // every flag is set by now
    for (int c = 0; c < nch_lp; c++) begin
      write_reg(chan_addr(c, `MCL_OFS_ISR), next_rand() & ~(32'd1 << `MCL_ISR_TC_BIT));
      write_reg(chan_addr(c, `MCL_OFS_ISR), next_rand() | (32'd1 << `MCL_ISR_TC_BIT));
    end
    write_reg(chan_addr(1, `MCL_OFS_TDR), next_rand());
    wait_drained();
    finish_test("transmit complete flags");

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
axil_pkg.sv
fifo_regs_pkg.sv
axil_write_decoder.sv
tx_fifo_channel.sv
tx_drain_arbiter.sv
axil_tx_fifos.sv
tb_axil_tx_fifos.sv

/* Makefile */
# tool, flags, top module and file list
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_axil_tx_fifos
FLIST     := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# a run that never reaches the pass line counts as a failure too
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi
	@grep -q "all tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
